// File: design/rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core #(
  parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  output logic [rv_pkg::XLEN-1:0] imem_addr,
  input  logic [rv_pkg::XLEN-1:0] imem_data,
  output logic [rv_pkg::XLEN-1:0] dmem_addr,
  input  logic [rv_pkg::XLEN-1:0] dmem_rdata,
  output logic [rv_pkg::XLEN-1:0] dmem_wdata,
  output logic                    dmem_we,
  output logic                    halt
);

  import rv_pkg::*;

  logic [XLEN-1:0]       pc;
  logic [XLEN-1:0]       pc_plus4;
  logic                  take_target;
  logic [XLEN-1:0]       target;

  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       imm;
  logic [ALU_OP_W-1:0]   alu_op;
  logic                  use_imm;
  logic                  reg_we;
  logic [WB_SEL_W-1:0]   wb_sel;
  logic                  is_store;
  logic                  is_branch;
  logic                  is_jal;
  logic                  is_jalr;
  logic                  is_auipc;
  logic [2:0]            branch_f3;
  logic                  dec_halt;

  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic [XLEN-1:0]       alu_result;
  logic [XLEN-1:0]       wb_data;

  rv_fetch #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clk         (clk),
    .rst         (rst),
    .halt        (dec_halt),
    .take_target (take_target),
    .target      (target),
    .pc          (pc),
    .pc_plus4    (pc_plus4)
  );

  rv_decode u_decode (
    .inst      (imem_data),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .imm       (imm),
    .alu_op    (alu_op),
    .use_imm   (use_imm),
    .reg_we    (reg_we),
    .wb_sel    (wb_sel),
    .is_store  (is_store),
    .is_branch (is_branch),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .is_auipc  (is_auipc),
    .branch_f3 (branch_f3),
    .halt      (dec_halt)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .we       (reg_we),
    .rd       (rd),
    .rd_data  (wb_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute u_execute (
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .imm         (imm),
    .pc          (pc),
    .alu_op      (alu_op),
    .use_imm     (use_imm),
    .is_branch   (is_branch),
    .is_jal      (is_jal),
    .is_jalr     (is_jalr),
    .is_auipc    (is_auipc),
    .branch_f3   (branch_f3),
    .alu_result  (alu_result),
    .take_target (take_target),
    .target      (target)
  );

  always_comb begin
    case (wb_sel)
      WB_LOAD:  wb_data = dmem_rdata;
      WB_LINK:  wb_data = pc_plus4;
      WB_UPPER: wb_data = imm;
      default:  wb_data = alu_result;
    endcase
  end

  assign imem_addr = pc;

  // Loads and stores share the rs1 + imm adder
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rs2_data;
  assign dmem_we    = is_store && !rst;
  assign halt       = dec_halt && !rst;

endmodule

`default_nettype wire

// File: design/rv_decode.sv
`timescale 1ns/100ps
`default_nettype none

module rv_decode (
  input  rv_pkg::inst_u                 inst,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs1,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs2,
  output logic [rv_pkg::REG_ADDR_W-1:0] rd,
  output logic [rv_pkg::XLEN-1:0]       imm,
  output logic [rv_pkg::ALU_OP_W-1:0]   alu_op,
  output logic                          use_imm,
  output logic                          reg_we,
  output logic [rv_pkg::WB_SEL_W-1:0]   wb_sel,
  output logic                          is_store,
  output logic                          is_branch,
  output logic                          is_jal,
  output logic                          is_jalr,
  output logic                          is_auipc,
  output logic [2:0]                    branch_f3,
  output logic                          halt
);

  import rv_pkg::*;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_u;
  logic            alt;

  // Maps funct3 to an ALU operation, alt picks sub or sra
  function automatic logic [ALU_OP_W-1:0] alu_select(input logic [2:0] f3,
                                                     input logic       sub_en,
                                                     input logic       sra_en);
    logic [ALU_OP_W-1:0] op;
    case (f3)
      F3_ADD:  op = sub_en ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = sra_en ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign rs1       = inst.r.rs1;
  assign rs2       = inst.r.rs2;
  assign rd        = inst.r.rd;
  assign branch_f3 = inst.r.funct3;
  assign alt       = inst.r.funct7[5];

  // Immediates, all sign-extended from bit 31
  assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
  assign imm_s = {{20{inst.r.funct7[6]}}, inst.r.funct7, inst.r.rd};
  assign imm_b = {{20{inst.r.funct7[6]}}, inst.r.rd[0], inst.r.funct7[5:0],
                  inst.r.rd[4:1], 1'b0};
  assign imm_j = {{12{inst.u.imm[19]}}, inst.u.imm[7:0], inst.u.imm[8],
                  inst.u.imm[18:9], 1'b0};
  assign imm_u = {inst.u.imm, 12'b0};

  always_comb begin
    imm       = imm_i;
    alu_op    = ALU_ADD;
    use_imm   = 1'b0;
    reg_we    = 1'b0;
    wb_sel    = WB_ALU;
    is_store  = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    is_auipc  = 1'b0;
    halt      = 1'b0;

    case (inst.r.opcode)
      OP_LUI: begin
        imm    = imm_u;
        reg_we = 1'b1;
        wb_sel = WB_UPPER;
      end
      OP_AUIPC: begin
        imm      = imm_u;
        reg_we   = 1'b1;
        is_auipc = 1'b1;
      end
      OP_JAL: begin
        imm    = imm_j;
        reg_we = 1'b1;
        wb_sel = WB_LINK;
        is_jal = 1'b1;
      end
      OP_JALR: begin
        reg_we  = 1'b1;
        wb_sel  = WB_LINK;
        is_jalr = 1'b1;
      end
      OP_BRANCH: begin
        imm       = imm_b;
        is_branch = 1'b1;
      end
      OP_LOAD: begin
        // Address is rs1 + imm through the adder
        use_imm = 1'b1;
        reg_we  = (inst.i.funct3 == F3_W);
        wb_sel  = WB_LOAD;
      end
      OP_STORE: begin
        imm      = imm_s;
        use_imm  = 1'b1;
        is_store = (inst.r.funct3 == F3_W);
      end
      OP_IMM: begin
        use_imm = 1'b1;
        reg_we  = 1'b1;
        alu_op  = alu_select(inst.i.funct3, 1'b0, alt);
      end
      OP_REG: begin
        reg_we = 1'b1;
        alu_op = alu_select(inst.r.funct3, alt, alt);
      end
      OP_SYSTEM: begin
        // ECALL only, every other field zero
        halt = (inst.i.imm == 12'd0) && (inst.i.rs1 == '0) &&
               (inst.i.funct3 == 3'd0) && (inst.i.rd == '0);
      end
      default: begin
        reg_we = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/rv_execute.sv
`timescale 1ns/100ps
`default_nettype none

module rv_execute (
  input  logic [rv_pkg::XLEN-1:0]     rs1_data,
  input  logic [rv_pkg::XLEN-1:0]     rs2_data,
  input  logic [rv_pkg::XLEN-1:0]     imm,
  input  logic [rv_pkg::XLEN-1:0]     pc,
  input  logic [rv_pkg::ALU_OP_W-1:0] alu_op,
  input  logic                        use_imm,
  input  logic                        is_branch,
  input  logic                        is_jal,
  input  logic                        is_jalr,
  input  logic                        is_auipc,
  input  logic [2:0]                  branch_f3,
  output logic [rv_pkg::XLEN-1:0]     alu_result,
  output logic                        take_target,
  output logic [rv_pkg::XLEN-1:0]     target
);

  import rv_pkg::*;

  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_out;
  logic [XLEN-1:0] pc_imm;
  logic [XLEN-1:0] rs1_imm;
  logic [4:0]      shamt;
  logic            branch_cond;

  assign op_b  = use_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:  alu_out = rs1_data + op_b;
      ALU_SUB:  alu_out = rs1_data - op_b;
      ALU_AND:  alu_out = rs1_data & op_b;
      ALU_OR:   alu_out = rs1_data | op_b;
      ALU_XOR:  alu_out = rs1_data ^ op_b;
      ALU_SLT:  alu_out = XLEN'($signed(rs1_data) < $signed(op_b));
      ALU_SLTU: alu_out = XLEN'(rs1_data < op_b);
      ALU_SLL:  alu_out = rs1_data << shamt;
      ALU_SRL:  alu_out = rs1_data >> shamt;
      ALU_SRA:  alu_out = $unsigned($signed(rs1_data) >>> shamt);
      default:  alu_out = '0;
    endcase
  end

  // Branch compare always on rs1 and rs2
  always_comb begin
    case (branch_f3)
      F3_BEQ:  branch_cond = (rs1_data == rs2_data);
      F3_BNE:  branch_cond = (rs1_data != rs2_data);
      F3_BLT:  branch_cond = ($signed(rs1_data) < $signed(rs2_data));
      F3_BGE:  branch_cond = ($signed(rs1_data) >= $signed(rs2_data));
      F3_BLTU: branch_cond = (rs1_data < rs2_data);
      F3_BGEU: branch_cond = (rs1_data >= rs2_data);
      default: branch_cond = 1'b0;
    endcase
  end

  assign pc_imm  = pc + imm;
  assign rs1_imm = rs1_data + imm;

  assign alu_result  = is_auipc ? pc_imm : alu_out;
  assign take_target = is_jal || is_jalr || (is_branch && branch_cond);

  // JALR target has bit 0 cleared
  assign target = is_jalr ? {rs1_imm[XLEN-1:1], 1'b0} : pc_imm;

endmodule

`default_nettype wire

// File: design/rv_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module rv_fetch #(
  parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    halt,
  input  logic                    take_target,
  input  logic [rv_pkg::XLEN-1:0] target,
  output logic [rv_pkg::XLEN-1:0] pc,
  output logic [rv_pkg::XLEN-1:0] pc_plus4
);

  import rv_pkg::*;

  logic [XLEN-1:0] next_pc;

  assign pc_plus4 = pc + XLEN'(4);

  // Jumps and taken branches win over sequential fetch
  assign next_pc = take_target ? target : pc_plus4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (!halt) begin
      pc <= next_pc;
    end
  end

  // PC frozen on ECALL, so the same instruction keeps halt high

endmodule

`default_nettype wire

// File: design/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // Major opcodes
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // Branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // ALU groups, shared by register and immediate forms
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // Only word access exists for loads and stores
  localparam logic [2:0] F3_W = 3'b010;

  localparam int ALU_OP_W = 4;

  localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
  localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd2;
  localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd3;
  localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd4;
  localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd7;
  localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd8;
  localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd9;

  // Write-back source select
  localparam int WB_SEL_W = 2;

  localparam logic [WB_SEL_W-1:0] WB_ALU   = 2'd0;
  localparam logic [WB_SEL_W-1:0] WB_LOAD  = 2'd1;
  localparam logic [WB_SEL_W-1:0] WB_LINK  = 2'd2;
  localparam logic [WB_SEL_W-1:0] WB_UPPER = 2'd3;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } inst_r_t;

  typedef struct packed {
    logic [11:0]           imm;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } inst_i_t;

  typedef struct packed {
    logic [19:0]           imm;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } inst_u_t;

  // One instruction word, three ways of reading it
  typedef union packed {
    inst_r_t r;
    inst_i_t i;
    inst_u_t u;
  } inst_u;

endpackage

`default_nettype wire

// File: design/rv_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module rv_regfile (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          we,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rd,
  input  logic [rv_pkg::XLEN-1:0]       rd_data,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs1,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs2,
  output logic [rv_pkg::XLEN-1:0]       rs1_data,
  output logic [rv_pkg::XLEN-1:0]       rs2_data
);

  import rv_pkg::*;

  localparam int NUM_REGS = 2 ** REG_ADDR_W;

  logic [XLEN-1:0] regs [NUM_REGS];

  // x0 stays zero from reset on, since writes to it are dropped
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sim.f --top-module tb_rv_core -o tb_rv_core &&
  ./obj_dir/tb_rv_core | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

// File: sim.f
design/rv_pkg.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_core.sv
tests/tb_rv_core.sv

// File: tests/rv_stim.mem
// Program word count and program words, data word count and data words,
// then the store count followed by expected stores as address, data pairs
00000063
// Setup: x1=5, x2=-3, x6=0x80000000, x13=0x6C, x14=0x35, store x2
00500093 FFD00113 80000337 06C00693 03500713 10202023
// Register ops into x3, each stored: add sub and or xor slt sltu sll srl sra
002081B3 10302223 402081B3 10302423 00E6F1B3 10302623
00E6E1B3 10302823 00E6C1B3 10302A23 001121B3 10302C23
001131B3 10302E23 001691B3 12302023 001351B3 12302223
401351B3 12302423
// Immediate ops: andi ori xori slti sltiu slli srli srai
00F6F193 12302623 0036E193 12302823 FFF6C193 12302A23
00012193 12302C23 FFF0B193 12302E23 00409193 14302023
00435193 14302223 40435193 14302423
// LUI, the LUI from setup, AUIPC at 0xB4
123451B7 14302623 14602823 00001197 14302A23
// JAL over two addi, then JALR with an odd offset landing on 0xD8
00C001EF 00100193 00200193 14302C23
00000217 00D202E7 00100293 14502E23
// Two loads stored back, then a write to x0 and a store of x0
00402183 16302023 00802183 16302223 05500013 16002423
// Branch pairs: not taken, then taken, fall-through sets a bit in x10
00208463 00156513 20A02023 00108463 00256513 20A02223
00109463 00456513 20A02423 00209463 00856513 20A02623
0020C463 01056513 20A02823 00114463 02056513 20A02A23
00115463 04056513 20A02C23 0020D463 08056513 20A02E23
00116463 10056513 22A02023 0020E463 20056513 22A02223
0020F463 40056513 22A02423 00117463 80056513 22A02623
// ECALL, then a store that must never run
00000073 30102023
// Data memory
00000003
13579BDF 2468ACE0 8642FDB9
// Expected stores
00000027
00000100 FFFFFFFD 00000104 00000002 00000108 00000008
0000010C 00000024 00000110 0000007D 00000114 00000059
00000118 00000001 0000011C 00000000 00000120 00000D80
00000124 04000000 00000128 FC000000 0000012C 0000000C
00000130 0000006F 00000134 FFFFFF93 00000138 00000001
0000013C 00000001 00000140 00000050 00000144 08000000
00000148 F8000000 0000014C 12345000 00000150 80000000
00000154 000010B4 00000158 000000C0 0000015C 000000D4
00000160 2468ACE0 00000164 8642FDB9 00000168 00000000
00000200 00000001 00000204 00000001 00000208 00000005
0000020C 00000005 00000210 00000015 00000214 00000015
00000218 00000055 0000021C 00000055 00000220 00000155
00000224 00000155 00000228 00000555 0000022C 00000555

// File: tests/tb_rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;

  localparam int MEM_WORDS   = 256;
  localparam int STIM_WORDS  = 512;
  localparam int RESET_TICKS = 16;
  localparam int HALT_LIMIT  = 2000;
  localparam int HOLD_CYCLES = 10;

  // sw x1, 0x300(x0) and ECALL
  localparam logic [31:0] STORE_INST = 32'h3010_2023;
  localparam logic [31:0] ECALL_INST = 32'h0000_0073;

  logic        clk;
  logic        rst;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_rdata;
  logic [31:0] dmem_wdata;
  logic        dmem_we;
  logic        halt;

  logic [31:0] stim     [STIM_WORDS];
  logic [31:0] imem     [MEM_WORDS];
  logic [31:0] dmem     [MEM_WORDS];
  logic [31:0] exp_addr [MEM_WORDS];
  logic [31:0] exp_data [MEM_WORDS];
  int          exp_count;
  int          store_count;
  logic        halt_seen;
  logic [31:0] halt_pc;

  rv_core #(
    .RESET_PC (32'h0000_0000)
  ) dut (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_rdata (dmem_rdata),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .halt       (halt)
  );

  always #50 clk = ~clk;

  // Both memories answer in the same cycle
  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped on first error");
  endtask

  // Background word, built from the byte address
  function automatic logic [31:0] fill_word(input int index);
    logic [15:0] addr;
    addr = 16'(index * 4);
    return {~addr, addr};
  endfunction

  task automatic load_memories();
    int idx;
    int prog_words;
    int data_words;
    $readmemh("tests/rv_stim.mem", stim);
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = fill_word(i);
      dmem[i] = fill_word(i);
    end
    prog_words = int'(stim[0]);
    idx        = 1 + prog_words;
    data_words = int'(stim[idx]);
    exp_count  = int'(stim[idx + 1 + data_words]);
    assert (prog_words <= MEM_WORDS && data_words <= MEM_WORDS && exp_count <= MEM_WORDS)
      else stop_on_error("Stimulus file holds more words than the memories can take");
    for (int i = 0; i < prog_words; i++) begin
      imem[i] = stim[1 + i];
    end
    // Halt address is that of the first ECALL in the program
    halt_pc = '1;
    for (int i = prog_words - 1; i >= 0; i--) begin
      if (imem[i] == ECALL_INST) begin
        halt_pc = 32'(i * 4);
      end
    end
    for (int i = 0; i < data_words; i++) begin
      dmem[i] = stim[idx + 1 + i];
    end
    idx = idx + 2 + data_words;
    // Expected stores come as address and data pairs
    for (int i = 0; i < exp_count; i++) begin
      exp_addr[i] = stim[idx + 2 * i];
      exp_data[i] = stim[idx + 2 * i + 1];
    end
  endtask

  task automatic check_store();
    assert (!halt_seen) else stop_on_error("A store happened after halt was raised");
    assert (store_count < exp_count) else stop_on_error("More stores than expected");
    assert (dmem_addr == exp_addr[store_count])
      else stop_on_error($sformatf("Mismatch on dmem_addr: got %08h, expected %08h",
                                   dmem_addr, exp_addr[store_count]));
    assert (dmem_wdata == exp_data[store_count])
      else stop_on_error($sformatf("Mismatch on dmem_wdata: got %08h, expected %08h",
                                   dmem_wdata, exp_data[store_count]));
    store_count++;
  endtask

  // Mid-cycle sampling, after the outputs have settled
  always @(negedge clk) begin
    if (rst) begin
      assert (!dmem_we && !halt) else stop_on_error("dmem_we or halt active during reset");
    end
    if (dmem_we) begin
      check_store();
    end
    if (halt) begin
      halt_seen = 1'b1;
    end
  end

  task automatic wait_for_halt();
    int cycles;
    cycles = 0;
    while (!halt && cycles < HALT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    assert (halt) else stop_on_error("Timeout: halt never came within 2000 cycles");
  endtask

  task automatic hold_halt();
    for (int i = 0; i < HOLD_CYCLES; i++) begin
      @(negedge clk);
      assert (halt) else stop_on_error("halt dropped while the core sat on ECALL");
      assert (imem_addr == halt_pc)
        else stop_on_error($sformatf("Mismatch on imem_addr: got %08h, expected %08h",
                                     imem_addr, halt_pc));
    end
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    halt_seen   = 1'b0;
    store_count = 0;
    exp_count   = 0;
    load_memories();

    // Store then ECALL at the reset PC while rst is high
    imem[0] = STORE_INST;
    repeat (RESET_TICKS / 2) @(posedge clk);
    imem[0] <= ECALL_INST;
    repeat (RESET_TICKS / 2) @(posedge clk);
    imem[0] <= stim[1];
    rst     <= 1'b0;

    @(negedge clk);
    assert (imem_addr == 32'h0000_0000)
      else stop_on_error($sformatf("Mismatch on imem_addr: got %08h, expected %08h",
                                   imem_addr, 32'h0000_0000));

    wait_for_halt();
    assert (imem_addr == halt_pc)
      else stop_on_error($sformatf("Mismatch on imem_addr: got %08h, expected %08h",
                                   imem_addr, halt_pc));
    hold_halt();

    assert (store_count == exp_count)
      else stop_on_error($sformatf("Mismatch on store count: got %0h, expected %0h",
                                   store_count, exp_count));
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire
